// File: verilog/arm_pkg.sv
`default_nettype none

package arm_pkg;

	typedef logic [31:0] word_t;     // instructions, pcs and the cpsr all share this width
	typedef logic [15:0] reg_mask_t; // one bit per architectural register, r15 stays clear

	// flag positions inside the cpsr
	localparam int CPSR_N = 31;
	localparam int CPSR_Z = 30;
	localparam int CPSR_C = 29;
	localparam int CPSR_V = 28;

	// the cond field in insn[31:28]
	typedef enum logic [3:0] {
		COND_EQ = 4'h0, COND_NE = 4'h1, COND_CS = 4'h2, COND_CC = 4'h3,
		COND_MI = 4'h4, COND_PL = 4'h5, COND_VS = 4'h6, COND_VC = 4'h7,
		COND_HI = 4'h8, COND_LS = 4'h9, COND_GE = 4'hA, COND_LT = 4'hB,
		COND_GT = 4'hC, COND_LE = 4'hD, COND_AL = 4'hE, COND_NV = 4'hF
	} cond_e;

	// data processing opcodes from insn[24:21]
	typedef enum logic [3:0] {
		ALU_AND = 4'h0, ALU_EOR = 4'h1, ALU_SUB = 4'h2, ALU_RSB = 4'h3,
		ALU_ADD = 4'h4, ALU_ADC = 4'h5, ALU_SBC = 4'h6, ALU_RSC = 4'h7,
		ALU_TST = 4'h8, ALU_TEQ = 4'h9, ALU_CMP = 4'hA, ALU_CMN = 4'hB,
		ALU_ORR = 4'hC, ALU_MOV = 4'hD, ALU_BIC = 4'hE, ALU_MVN = 4'hF
	} alu_op_e;

	// decode classes, listed in the order the decoder tries them
	typedef enum logic [4:0] {
		CLS_MUL,        // mul and mla
		CLS_MRS,        // psr to register
		CLS_MSR,        // register to whole psr
		CLS_MSR_FLAGS,  // register or immediate to psr flag bits
		CLS_SWP,        // atomic swap
		CLS_BX,         // branch and exchange
		CLS_HDATA_REG,  // halfword transfer with register offset
		CLS_HDATA_IMM,  // halfword transfer with immediate offset
		CLS_ALU,        // data processing
		CLS_UNDEF,      // the undefined hole inside the single transfer space
		CLS_LDRSTR,     // single data transfer
		CLS_LDMSTM,     // block data transfer
		CLS_BRANCH,     // b and bl
		CLS_LDCSTC,     // coprocessor data transfer
		CLS_CDP,        // coprocessor data operation
		CLS_MRCMCR,     // coprocessor register transfer
		CLS_SWI         // software interrupt
	} insn_class_e;

	// what an instruction reads and writes, as seen by the scoreboard
	typedef struct packed {
		logic      use_cpsr; // reads the flags, for its condition or a carry in
		reg_mask_t use_regs;
		logic      def_cpsr; // writes the flags
		reg_mask_t def_regs;
	} dep_t;

	// one pipeline slot from issue onwards
	typedef struct packed {
		logic  bubble; // slot is empty or was squashed
		word_t pc;
		word_t insn;
	} stage_t;

endpackage

`default_nettype wire

// File: verilog/insn_deps.sv
`timescale 1ns/1ps
`default_nettype none

module insn_deps (
	input  wire arm_pkg::word_t insn,
	output arm_pkg::dep_t       deps
);

	localparam arm_pkg::reg_mask_t NO_PC = 16'h7FFF; // strips r15 out of a register list

	logic [3:0]           rn;       // multiply puts rd here
	logic [3:0]           rd;       // multiply puts its accumulate register here
	logic [3:0]           rs;
	logic [3:0]           rm;
	logic                 cond_used;
	arm_pkg::alu_op_e     alu_opc;
	arm_pkg::insn_class_e cls;

	assign rn = insn[19:16];
	assign rd = insn[15:12];
	assign rs = insn[11:8];
	assign rm = insn[3:0];
	assign alu_opc = arm_pkg::alu_op_e'(insn[24:21]);

	// AL and NV are decided without looking at the flags
	assign cond_used = (insn[31:28] != arm_pkg::COND_AL) && (insn[31:28] != arm_pkg::COND_NV);

	// the pc is always available, so it never shows up as a dependency
	function automatic arm_pkg::reg_mask_t idxbit(input logic [3:0] r);
		idxbit = (r == 4'd15) ? '0 : (arm_pkg::reg_mask_t'(1) << r);
	endfunction

	function automatic logic flags_only(input arm_pkg::alu_op_e op);
		flags_only = (op == arm_pkg::ALU_TST) || (op == arm_pkg::ALU_TEQ) ||
			(op == arm_pkg::ALU_CMP) || (op == arm_pkg::ALU_CMN);
	endfunction

	// LSL #0 passes the old carry through and ROR #0 is RRX, both read C
	function automatic logic shift_needs_carry(input logic [7:0] shift);
		shift_needs_carry = !shift[0] && (shift[7:3] == 5'd0) &&
			((shift[2:1] == 2'b00) || (shift[2:1] == 2'b11));
	endfunction

	// first match wins, so the narrow patterns sit above the wide ones they overlap
	always_comb
	begin
		casez (insn[27:0])
		28'b0000_00??_????_????_????_1001_????: cls = arm_pkg::CLS_MUL;
		28'b0001_0?00_1111_????_0000_0000_0000: cls = arm_pkg::CLS_MRS;
		28'b0001_0?10_1001_1111_0000_0000_????: cls = arm_pkg::CLS_MSR;
		28'b00?1_0?10_1000_1111_????_????_????: cls = arm_pkg::CLS_MSR_FLAGS;
		28'b0001_0?00_????_????_0000_1001_????: cls = arm_pkg::CLS_SWP;
		28'b0001_0010_1111_1111_1111_0001_????: cls = arm_pkg::CLS_BX;
		28'b000?_?0??_????_????_0000_1??1_????: cls = arm_pkg::CLS_HDATA_REG;
		28'b000?_?1??_????_????_????_1??1_????: cls = arm_pkg::CLS_HDATA_IMM;
		28'b00??_????_????_????_????_????_????: cls = arm_pkg::CLS_ALU;
		28'b011?_????_????_????_????_???1_????: cls = arm_pkg::CLS_UNDEF;
		28'b01??_????_????_????_????_????_????: cls = arm_pkg::CLS_LDRSTR;
		28'b100?_????_????_????_????_????_????: cls = arm_pkg::CLS_LDMSTM;
		28'b101?_????_????_????_????_????_????: cls = arm_pkg::CLS_BRANCH;
		28'b110?_????_????_????_????_????_????: cls = arm_pkg::CLS_LDCSTC;
		28'b1110_????_????_????_????_???0_????: cls = arm_pkg::CLS_CDP;
		28'b1110_????_????_????_????_???1_????: cls = arm_pkg::CLS_MRCMCR;
		28'b1111_????_????_????_????_????_????: cls = arm_pkg::CLS_SWI;
		default: cls = arm_pkg::CLS_UNDEF; // nothing lands here, the table is complete
		endcase
	end

	always_comb
	begin
		// most classes only read the flags for their condition
		deps = '{use_cpsr: cond_used, use_regs: '0, def_cpsr: 1'b0, def_regs: '0};
		case (cls)
		arm_pkg::CLS_MUL:
		begin
			deps.use_regs = (insn[21] ? idxbit(rd) : '0) | idxbit(rs) | idxbit(rm); // bit 21 is accumulate
			deps.def_cpsr = insn[20];
			deps.def_regs = idxbit(rn);
		end
		arm_pkg::CLS_MRS:
		begin
			deps.use_cpsr = cond_used || !insn[22]; // reading the cpsr itself rather than the spsr
			deps.def_regs = idxbit(rd);
		end
		arm_pkg::CLS_MSR:
		begin
			deps.use_regs = idxbit(rm);
			deps.def_cpsr = 1'b1;
		end
		arm_pkg::CLS_MSR_FLAGS:
		begin
			deps.use_regs = insn[25] ? '0 : idxbit(rm); // immediate form reads no register
			deps.def_cpsr = 1'b1;
		end
		arm_pkg::CLS_SWP:
		begin
			deps.use_regs = idxbit(rn) | idxbit(rm);
			deps.def_regs = idxbit(rd);
		end
		arm_pkg::CLS_BX: deps.use_regs = idxbit(rm);
		arm_pkg::CLS_HDATA_REG, arm_pkg::CLS_HDATA_IMM:
		begin
			// loads write rd, stores read it; only the register form has an rm
			deps.use_regs = idxbit(rn) | (insn[20] ? '0 : idxbit(rd)) |
				((cls == arm_pkg::CLS_HDATA_REG) ? idxbit(rm) : '0);
			deps.def_regs = insn[20] ? idxbit(rd) : '0;
		end
		arm_pkg::CLS_ALU:
		begin
			deps.use_cpsr = cond_used || (!insn[25] && shift_needs_carry(insn[11:4]));
			deps.use_regs = (insn[25] ? '0 : (insn[4] ? (idxbit(rs) | idxbit(rm)) : idxbit(rm))) |
				(((alu_opc != arm_pkg::ALU_MOV) && (alu_opc != arm_pkg::ALU_MVN)) ? idxbit(rn) : '0);
			deps.def_cpsr = insn[20];
			deps.def_regs = flags_only(alu_opc) ? '0 : idxbit(rd);
		end
		arm_pkg::CLS_LDRSTR:
		begin
			deps.use_regs = idxbit(rn) | (insn[25] ? idxbit(rm) : '0) | (insn[20] ? '0 : idxbit(rd));
			deps.def_regs = insn[20] ? idxbit(rd) : '0;
		end
		arm_pkg::CLS_LDMSTM:
		begin
			deps.use_regs = idxbit(rn) | (insn[20] ? '0 : (insn[15:0] & NO_PC));
			deps.def_cpsr = insn[22]; // the S bit, covers the spsr restore case too
			deps.def_regs = (insn[21] ? idxbit(rn) : '0) | (insn[20] ? (insn[15:0] & NO_PC) : '0);
		end
		arm_pkg::CLS_BRANCH: deps.def_regs = insn[24] ? idxbit(4'd14) : '0; // bl writes lr
		arm_pkg::CLS_LDCSTC:
		begin
			deps.use_regs = idxbit(rn);
			deps.def_regs = insn[21] ? idxbit(rn) : '0; // base writeback
		end
		arm_pkg::CLS_MRCMCR:
		begin
			deps.use_regs = insn[20] ? '0 : idxbit(rd);
			deps.def_regs = insn[20] ? idxbit(rd) : '0;
		end
		arm_pkg::CLS_CDP, arm_pkg::CLS_SWI: ; // condition only
		default: deps.use_cpsr = 1'b0; // undefined words carry no dependencies at all
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/cond_check.sv
`timescale 1ns/1ps
`default_nettype none

module cond_check (
	input  wire arm_pkg::cond_e cond,
	input  wire arm_pkg::word_t cpsr,
	output logic                cond_met
);

	logic n, z, c, v;

	assign n = cpsr[arm_pkg::CPSR_N];
	assign z = cpsr[arm_pkg::CPSR_Z];
	assign c = cpsr[arm_pkg::CPSR_C];
	assign v = cpsr[arm_pkg::CPSR_V];

	always_comb
	begin
		case (cond)
		arm_pkg::COND_EQ: cond_met = z;
		arm_pkg::COND_NE: cond_met = !z;
		arm_pkg::COND_CS: cond_met = c;
		arm_pkg::COND_CC: cond_met = !c;
		arm_pkg::COND_MI: cond_met = n;
		arm_pkg::COND_PL: cond_met = !n;
		arm_pkg::COND_VS: cond_met = v;
		arm_pkg::COND_VC: cond_met = !v;
		arm_pkg::COND_HI: cond_met = c && !z;       // unsigned higher
		arm_pkg::COND_LS: cond_met = !c || z;
		arm_pkg::COND_GE: cond_met = (n == v);      // signed compares go through n xor v
		arm_pkg::COND_LT: cond_met = (n != v);
		arm_pkg::COND_GT: cond_met = !z && (n == v);
		arm_pkg::COND_LE: cond_met = z || (n != v);
		arm_pkg::COND_AL: cond_met = 1'b1;
		default: cond_met = 1'b0; // NV never executes
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 stall,     // freeze from the later stages
	input  wire                 flush,
	input  wire                 in_bubble,
	input  wire arm_pkg::word_t insn,
	input  wire arm_pkg::word_t pc,
	input  wire arm_pkg::dep_t  deps,
	input  wire                 cond_met,
	output logic                issue_stall,
	output arm_pkg::stage_t     issued
);

	// scoreboard slots, ex belongs to the slot in issued and mem to the one behind it
	// once an instruction is past memory its result counts as written
	logic               ex_def_cpsr;
	arm_pkg::reg_mask_t ex_def_regs;
	logic               mem_def_cpsr;
	arm_pkg::reg_mask_t mem_def_regs;

	logic waiting_cpsr;
	logic waiting_regs;
	logic waiting;
	logic squash;
	logic delayed_flush; // a flush that could not be applied while stalled

	assign waiting_cpsr = deps.use_cpsr && (ex_def_cpsr || mem_def_cpsr);
	assign waiting_regs = |(deps.use_regs & (ex_def_regs | mem_def_regs));
	assign waiting = waiting_cpsr || waiting_regs;

	// a bubble or a flushed slot has nothing to wait for, so only a live hazard holds upstream
	assign issue_stall = (waiting && !in_bubble && !flush) || stall;

	// anything that turns the outgoing slot into a bubble
	assign squash = in_bubble || waiting || !cond_met || flush || delayed_flush;

	always_ff @(posedge clk)
	begin
		if (rst)
			delayed_flush <= 1'b0;
		else if (flush && issue_stall)
			delayed_flush <= 1'b1; // cannot squash anything this cycle, keep it for later
		else if (!issue_stall)
			delayed_flush <= 1'b0; // a slot was taken this cycle and got squashed
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ex_def_cpsr <= 1'b0;
			ex_def_regs <= '0;
			mem_def_cpsr <= 1'b0;
			mem_def_regs <= '0;
		end
		else if (!stall)
		begin
			mem_def_cpsr <= ex_def_cpsr;
			mem_def_regs <= ex_def_regs;
			ex_def_cpsr <= squash ? 1'b0 : deps.def_cpsr; // squashed slots write nothing
			ex_def_regs <= squash ? '0 : deps.def_regs;
		end
	end

	// the issue register itself, pc and insn ride along without reset
	always_ff @(posedge clk)
	begin
		if (rst)
			issued.bubble <= 1'b1;
		else if (!stall)
		begin
			issued.bubble <= squash;
			issued.pc <= pc;
			issued.insn <= insn;
		end
	end

	// a slot held back by a hazard must not also leave as a live instruction
	a_hazard_issues_bubble: assert property (@(posedge clk) disable iff (rst)
		(issue_stall && !stall) |=> issued.bubble)
		else $error("issue_stage: hazarded slot issued live");

	// an empty slot in execute leaves nothing behind for later slots to wait on
	a_bubble_defines_nothing: assert property (@(posedge clk) disable iff (rst)
		issued.bubble |-> ((ex_def_regs == '0) && !ex_def_cpsr))
		else $error("issue_stage: empty issue slot still holds defines");

endmodule

`default_nettype wire

// File: verilog/exec_mem_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module exec_mem_pipe (
	input  wire                  clk,
	input  wire                  rst,
	input  wire                  stall,
	input  wire arm_pkg::stage_t issued,
	output arm_pkg::stage_t      retire
);

	// execute and memory stage registers
	// a later ALU hangs off ex_q and the data memory off mem_q
	arm_pkg::stage_t ex_q;
	arm_pkg::stage_t mem_q;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ex_q.bubble <= 1'b1; // only the bubble bits are control state
			mem_q.bubble <= 1'b1;
		end
		else if (!stall)
		begin
			ex_q <= issued;
			mem_q <= ex_q;
		end
	end

	assign retire = mem_q; // whatever leaves memory retires

endmodule

`default_nettype wire

// File: verilog/issue_top.sv
`timescale 1ns/1ps
`default_nettype none

module issue_top (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 stall,     // global freeze from later stages
	input  wire                 flush,
	input  wire                 in_bubble, // marks an empty input slot
	input  wire arm_pkg::word_t insn,
	input  wire arm_pkg::word_t pc,
	input  wire arm_pkg::word_t cpsr,
	output logic                issue_stall, // upstream holds insn and pc while high
	output arm_pkg::stage_t     retire
);

	arm_pkg::dep_t   deps;
	arm_pkg::cond_e  cond;
	logic            cond_met;
	arm_pkg::stage_t issued;

	assign cond = arm_pkg::cond_e'(insn[31:28]);

	insn_deps u_deps (
		.insn (insn),
		.deps (deps)
	);

	cond_check u_cond (
		.cond     (cond),
		.cpsr     (cpsr),
		.cond_met (cond_met)
	);

	// stall goes to both the issue stage and the carrier so everything freezes together
	issue_stage u_issue (
		.clk         (clk),
		.rst         (rst),
		.stall       (stall),
		.flush       (flush),
		.in_bubble   (in_bubble),
		.insn        (insn),
		.pc          (pc),
		.deps        (deps),
		.cond_met    (cond_met),
		.issue_stall (issue_stall),
		.issued      (issued)
	);

	exec_mem_pipe u_exec_mem (
		.clk    (clk),
		.rst    (rst),
		.stall  (stall),
		.issued (issued),
		.retire (retire)
	);

endmodule

`default_nettype wire

// File: tb/tb_issue_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_issue_top;

	logic clk, rst, stall, flush, in_bubble;
	arm_pkg::word_t insn, pc, cpsr;
	logic issue_stall;
	arm_pkg::stage_t retire;

	logic [15:0] lfsr = 16'd33775;
	// model of the slot on the inputs, built from the same fields as insn
	logic m_use_c, m_def_c;
	arm_pkg::reg_mask_t m_use_r, m_def_r;
	logic [3:0] m_cond;
	// model scoreboard, delayed flush and the three pipe registers
	logic ex_c, mem_c, dflush, exp_stall, waiting, squash, advanced;
	arm_pkg::reg_mask_t ex_r, mem_r;
	arm_pkg::stage_t m_iss, m_ex, m_mem;
	int n_expected, n_retired, held, cyc;
	logic [31:0] r;

	issue_top u_dut (.clk(clk), .rst(rst), .stall(stall), .flush(flush), .in_bubble(in_bubble),
		.insn(insn), .pc(pc), .cpsr(cpsr), .issue_stall(issue_stall), .retire(retire));

	initial
	begin
		clk = 1'b0;
		forever #5 clk = !clk;
	end

	// x^16 + x^14 + x^13 + x^11, one step per bit taken
	function automatic logic [31:0] draw(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic arm_pkg::reg_mask_t rbit(input logic [3:0] i);
		return (i == 4'd15) ? 16'h0000 : (16'h0001 << i); // r15 is never tracked
	endfunction

	// the ARM condition table on the NZCV flags
	function automatic logic cond_pass(input logic [3:0] c, input logic [3:0] f);
		logic n, z, cy, v;
		{n, z, cy, v} = f;
		case (c)
		4'h0: return z;
		4'h1: return !z;
		4'h2: return cy;
		4'h3: return !cy;
		4'h4: return n;
		4'h5: return !n;
		4'h6: return v;
		4'h7: return !v;
		4'h8: return cy && !z;
		4'h9: return !cy || z;
		4'hA: return n == v;
		4'hB: return n != v;
		4'hC: return !z && (n == v);
		4'hD: return z || (n != v);
		4'hE: return 1'b1;
		default: return 1'b0;
		endcase
	endfunction

	task automatic check_stall(input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t: issue_stall is %b, model expects %b", $time, got, exp);
			$display("TEST FAIL");
			$fatal(1);
		end
	endtask

	// pc and insn only mean something on a live slot
	task automatic check_stage(input arm_pkg::stage_t got, input arm_pkg::stage_t exp);
		if (got.bubble !== exp.bubble ||
			(!exp.bubble && (got.pc !== exp.pc || got.insn !== exp.insn)))
		begin
			$display("CHECK FAILED at %0t: retire %b/%08x/%08x, model %b/%08x/%08x", $time,
				got.bubble, got.pc, got.insn, exp.bubble, exp.pc, exp.insn);
			$display("TEST FAIL");
			$fatal(1);
		end
	endtask

	// builds a new instruction and its expected masks, sets the model fields immediately
	task automatic make_slot(output arm_pkg::word_t w, output logic bub);
		logic [31:0] cls, c, op, s, rn, rd, rm, x;
		cls = draw(3);
		c = draw(2);
		if (c == 0)
			c = draw(4); // one in four gets a random condition
		else
			c = 4'hE;
		op = draw(4);
		s = draw(1);
		rn = draw(4);
		rd = draw(4);
		rm = draw(4);
		x = draw(12);
		if (op[3:2] == 2'b10)
			s = 1; // compares without S would be misc encodings
		m_cond = c[3:0];
		m_use_c = (c[3:0] != 4'hE) && (c[3:0] != 4'hF);
		m_use_r = '0;
		m_def_c = 1'b0;
		m_def_r = '0;
		case (cls)
		0, 1, 6, 7:
		begin
			if (cls == 0)
				w = {c[3:0], 3'b001, op[3:0], s[0], rn[3:0], rd[3:0], x[11:0]};
			else
			begin
				w = {c[3:0], 3'b000, op[3:0], s[0], rn[3:0], rd[3:0], x[11:5], 1'b0, rm[3:0]};
				m_use_r = rbit(rm[3:0]);
				// lsl #0 and rrx take the old carry
				if (x[11:7] == 0 && (x[6:5] == 2'b00 || x[6:5] == 2'b11))
					m_use_c = 1'b1;
			end
			if (op[3:0] != 4'hD && op[3:0] != 4'hF)
				m_use_r |= rbit(rn[3:0]);
			if (op[3:2] != 2'b10)
				m_def_r = rbit(rd[3:0]);
			m_def_c = s[0];
		end
		2:
		begin
			w = {c[3:0], 3'b010, 1'b1, op[1:0], 1'b0, s[0], rn[3:0], rd[3:0], x[11:0]};
			m_use_r = rbit(rn[3:0]) | (s[0] ? 16'h0 : rbit(rd[3:0])); // a store reads rd
			m_def_r = s[0] ? rbit(rd[3:0]) : 16'h0;
		end
		3:
		begin
			w = {c[3:0], 3'b101, s[0], op[3:0], rn[3:0], rd[3:0], x[11:0]};
			m_def_r = s[0] ? rbit(4'd14) : 16'h0; // bl writes the link register
		end
		4:
		begin
			w = {c[3:0], 5'b00010, s[0], 2'b00, 4'hF, rd[3:0], 12'h000};
			m_use_c = m_use_c || !s[0]; // mrs from the cpsr reads the flags
			m_def_r = rbit(rd[3:0]);
		end
		default:
		begin
			w = {c[3:0], 5'b00010, s[0], 2'b10, 4'h9, 4'hF, 8'h00, rm[3:0]};
			m_use_r = rbit(rm[3:0]);
			m_def_c = 1'b1;
		end
		endcase
		x = draw(3);
		bub = (x[2:0] == 0);
	endtask

	initial
	begin
		arm_pkg::word_t w;
		logic b;
		rst = 1'b1;
		stall = 1'b0;
		flush = 1'b0;
		cpsr = '0;
		pc = 32'h0000_1000;
		make_slot(w, b);
		insn = w;
		in_bubble = 1'b1;
		{ex_c, mem_c, dflush, advanced} = '0;
		ex_r = '0;
		mem_r = '0;
		m_iss = '{bubble: 1'b1, pc: '0, insn: '0};
		m_ex = m_iss;
		m_mem = m_iss;
		{n_expected, n_retired, held} = '0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		for (cyc = 0; cyc < 3000; cyc++)
		begin
			@(negedge clk);
			waiting = (m_use_c && (ex_c || mem_c)) || |(m_use_r & (ex_r | mem_r));
			exp_stall = (waiting && !in_bubble && !flush) || stall;
			squash = in_bubble || waiting || !cond_pass(m_cond, cpsr[31:28]) || flush || dflush;
			check_stall(issue_stall, exp_stall);
			check_stage(retire, m_mem);
			if (advanced && !retire.bubble)
				n_retired++;
			held = exp_stall ? held + 1 : 0;
			if (held > 40)
			begin
				$display("issue_stall stayed high for too long while waiting for a slot to be taken");
				$display("TEST FAIL");
				$fatal(1);
			end
			// model registers take the edge that follows
			if (flush && exp_stall)
				dflush = 1'b1;
			else if (!exp_stall)
				dflush = 1'b0;
			advanced = !stall;
			if (!stall)
			begin
				mem_c = ex_c;
				mem_r = ex_r;
				ex_c = squash ? 1'b0 : m_def_c;
				ex_r = squash ? '0 : m_def_r;
				m_mem = m_ex;
				m_ex = m_iss;
				m_iss = '{bubble: squash, pc: pc, insn: insn};
				if (!squash)
					n_expected++;
			end
			@(posedge clk);
			if (!exp_stall)
			begin
				make_slot(w, b);
				insn <= w;
				in_bubble <= (cyc > 2900) ? 1'b1 : b; // the last slots are empty so the pipe drains
				pc <= pc + 4;
			end
			r = draw(4);
			flush <= (r[3:0] == 0) && (cyc <= 2900);
			r = draw(3);
			stall <= (r[2:0] == 0) && (cyc <= 2900);
			r = draw(3);
			if (r[2:0] == 0)
			begin
				r = draw(4);
				cpsr <= {r[3:0], 28'h0};
			end
		end
		if (n_retired == n_expected && n_expected > 0)
		begin
			$display("TEST PASS");
			$finish;
		end
		else
		begin
			$display("CHECK FAILED at %0t: %0d slots retired, model expects %0d", $time,
				n_retired, n_expected);
			$display("TEST FAIL");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

// File: compile.f
verilog/arm_pkg.sv
verilog/insn_deps.sv
verilog/cond_check.sv
verilog/issue_stage.sv
verilog/exec_mem_pipe.sv
verilog/issue_top.sv
tb/tb_issue_top.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log for the fail message
verilator --binary --timing --assert --Wno-fatal --top-module tb_issue_top \
	-f compile.f -o sim_tb > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1
grep -q "TEST PASS" sim.log && exit 0 || exit 1
